// File: source/conv1_pkg.sv
package conv1_pkg;

  // ============================================================
  // layer geometry and arithmetic
  // ============================================================
  localparam int CH_NUM    = 4;     // input channels, also slices per word
  localparam int BW_ACT    = 12;
  localparam int BW_PARAM  = 8;
  localparam int TAPS      = 9;     // 3x3 kernel
  localparam int GRID      = 6;     // compute positions per side
  localparam int ACC_SHIFT = 7;
  localparam int OUT_MAX   = 2047;

  // channel 0 in the top slice; lane = dy*2 + dx, lane 0 lowest
  typedef logic [0:CH_NUM-1][3:0][BW_ACT-1:0] act_word_t;

  // row-major taps, tap 0 on top
  typedef logic [0:TAPS-1][BW_PARAM-1:0] weight_word_t;

  typedef struct packed {
    logic [5:0] a0;
    logic [5:0] a1;
    logic [5:0] a2;
    logic [5:0] a3;
  } act_rd_t;

  typedef struct packed {
    logic [2:0] row;
    logic [2:0] col;
    logic [1:0] sub;    // output pixel inside the position
    logic [2:0] ofmap;
    logic       fire;   // real compute cycle
  } wb_cmd_t;

  typedef struct packed {
    logic                       wen;       // active low
    logic [4:0]                 addr;
    logic [0:CH_NUM-1][3:0]     wordmask;  // 0 = write lane
    act_word_t                  wdata;
  } out_wr_t;

  typedef enum logic [1:0] {
    idle,
    load,
    compute
  } layer_state_e;

endpackage

// File: source/conv1_sequencer.sv
`timescale 1ns/1ps

module conv1_sequencer #(
  parameter int OFMAP_NUM = 8
) (
  input  logic               clk,
  input  logic               srst_n,
  input  logic               enable,
  output conv1_pkg::act_rd_t act_rd,
  output logic [8:0]         weight_raddr,
  output logic [5:0]         bias_raddr,
  output logic [1:0]         load_idx,
  output logic               load_strobe,
  output conv1_pkg::wb_cmd_t cmd,
  output logic               done
);

  localparam logic [2:0] last_idx = 3'(conv1_pkg::GRID - 1);
  localparam logic [2:0] last_map = 3'(OFMAP_NUM - 1);

  conv1_pkg::layer_state_e state;
  logic [2:0] cnt;       // load step
  logic [2:0] row;
  logic [2:0] col;
  logic [1:0] sub;
  logic [2:0] ofmap;
  logic [2:0] rd_row;    // one position ahead of row/col
  logic [2:0] rd_col;
  logic       last_pos;
  logic       ld_strobe_q;
  logic [1:0] ld_idx_q;
  logic [2:0] qr_even;
  logic [2:0] qr_odd;
  logic [2:0] qc_even;
  logic [2:0] qc_odd;

  function automatic logic [5:0] quad_addr(input logic [2:0] qr, input logic [2:0] qc);
    return {1'b0, qr, 2'b00} + {3'b000, qc};
  endfunction

  assign last_pos = (row == last_idx) && (col == last_idx) && (sub == 2'd3);

  // quad/2 of the even and odd quad row/col covered by the read position
  assign qr_even = (rd_row + 3'd1) >> 1;
  assign qr_odd  = rd_row >> 1;
  assign qc_even = (rd_col + 3'd1) >> 1;
  assign qc_odd  = rd_col >> 1;

  // ============================================================
  // layer FSM and counters
  // ============================================================
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      state  <= conv1_pkg::idle;
      cnt    <= '0;
      row    <= '0;
      col    <= '0;
      sub    <= '0;
      ofmap  <= '0;
      rd_row <= '0;
      rd_col <= '0;
    end else begin
      case (state)
        conv1_pkg::idle: begin
          if (enable) state <= conv1_pkg::load;
        end
        conv1_pkg::load: begin
          cnt <= cnt + 3'd1;
          if (cnt == 3'd5) begin
            state  <= conv1_pkg::compute;
            cnt    <= '0;
            rd_col <= 3'd1;  // position 0 already addressed
          end
        end
        conv1_pkg::compute: begin
          sub <= sub + 2'd1;
          if (last_pos) begin
            row    <= '0;
            col    <= '0;
            rd_row <= '0;
            rd_col <= '0;
            if (ofmap == last_map) begin
              state <= conv1_pkg::idle;
              ofmap <= '0;
            end else begin
              state <= conv1_pkg::load;
              ofmap <= ofmap + 3'd1;
            end
          end else if (sub == 2'd3) begin
            if (col == last_idx) begin
              row <= row + 3'd1;
              col <= '0;
            end else begin
              col <= col + 3'd1;
            end
            if (rd_col == last_idx) begin
              rd_row <= rd_row + 3'd1;
              rd_col <= '0;
            end else begin
              rd_col <= rd_col + 3'd1;
            end
          end
        end
        default: state <= conv1_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      cmd         <= '0;
      done        <= 1'b0;
      ld_strobe_q <= 1'b0;
      load_strobe <= 1'b0;
    end else begin
      cmd.row     <= row;
      cmd.col     <= col;
      cmd.sub     <= sub;
      cmd.ofmap   <= ofmap;
      cmd.fire    <= (state == conv1_pkg::compute);
      done        <= (state == conv1_pkg::compute) && last_pos && (ofmap == last_map);
      ld_strobe_q <= (state == conv1_pkg::load) && !cnt[2];
      load_strobe <= ld_strobe_q;  // lines up with weight read data
    end
  end

  // SRAM addresses
  always_ff @(posedge clk) begin
    ld_idx_q     <= cnt[1:0];
    load_idx     <= ld_idx_q;
    weight_raddr <= {4'b0000, ofmap, cnt[1:0]};
    bias_raddr   <= {3'b000, ofmap};
    act_rd.a0    <= quad_addr(qr_even, qc_even);
    act_rd.a1    <= quad_addr(qr_even, qc_odd);
    act_rd.a2    <= quad_addr(qr_odd, qc_even);
    act_rd.a3    <= quad_addr(qr_odd, qc_odd);
  end

endmodule

// File: source/conv1_operand_buffer.sv
`timescale 1ns/1ps

module conv1_operand_buffer (
  input  logic                          clk,
  input  logic                          srst_n,
  input  conv1_pkg::act_word_t          act_rdata [4],
  input  conv1_pkg::weight_word_t       weight_rdata,
  input  logic [conv1_pkg::BW_PARAM-1:0] bias_rdata,
  input  logic [1:0]                    load_idx,
  input  logic                          load_strobe,
  input  conv1_pkg::wb_cmd_t            cmd_in,
  input  logic                          done_in,
  output conv1_pkg::act_word_t          window [4],
  output conv1_pkg::weight_word_t       weights [4],
  output logic [conv1_pkg::BW_PARAM-1:0] bias,
  output conv1_pkg::wb_cmd_t            cmd_out,
  output logic                          done_out
);

  logic [1:0] parity;

  // bank holding the top-left quad of the position
  assign parity = {cmd_in.row[0], cmd_in.col[0]};

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      cmd_out  <= '0;
      done_out <= 1'b0;
    end else begin
      cmd_out  <= cmd_in;
      done_out <= done_in;
    end
  end

  // ============================================================
  // weights and bias, captured during load
  // ============================================================
  always_ff @(posedge clk) begin
    if (load_strobe) begin
      weights[load_idx] <= weight_rdata;
      bias              <= bias_rdata;  // same address all load long
    end
  end

  // ============================================================
  // activation window
  // ============================================================
  // read data is stable for this position on sub 0, held for the rest
  always_ff @(posedge clk) begin
    if (cmd_in.sub == 2'd0) begin
      for (int i = 0; i < 4; i++) begin
        window[i] <= act_rdata[2'(i) ^ parity];  // 0 tl, 1 tr, 2 bl, 3 br
      end
    end
  end

endmodule

// File: source/conv1_pe.sv
`timescale 1ns/1ps

module conv1_pe (
  input  logic                          clk,
  input  logic                          srst_n,
  input  conv1_pkg::act_word_t          window [4],
  input  conv1_pkg::weight_word_t       weights [4],
  input  logic [conv1_pkg::BW_PARAM-1:0] bias,
  input  conv1_pkg::wb_cmd_t            cmd_in,
  input  logic                          done_in,
  output logic [conv1_pkg::BW_ACT-1:0]  pixel,
  output conv1_pkg::wb_cmd_t            cmd_out,
  output logic                          done_out
);

  localparam int acc_w = 28;

  logic signed [acc_w-1:0]        acc;
  logic signed [acc_w-1:0]        shifted;
  logic [conv1_pkg::BW_ACT-1:0]   result;

  // 36 taps over the 3x3 window picked by sub
  always_comb begin : mac
    logic [1:0]                   py;
    logic [1:0]                   px;
    logic [conv1_pkg::BW_ACT-1:0] act;
    acc = acc_w'($signed(bias)) <<< conv1_pkg::ACC_SHIFT;
    for (int c = 0; c < conv1_pkg::CH_NUM; c++) begin
      for (int k = 0; k < conv1_pkg::TAPS; k++) begin
        py  = cmd_in.sub[1] + 2'(k / 3);
        px  = cmd_in.sub[0] + 2'(k % 3);
        act = window[{py[1], px[1]}][c][{py[0], px[0]}];
        acc = acc + $signed(weights[c][k]) * $signed({1'b0, act});  // act unsigned
      end
    end
  end

  // relu, scale back, saturate
  always_comb begin
    shifted = acc >>> conv1_pkg::ACC_SHIFT;
    if (acc < 0) begin
      result = '0;
    end else if (shifted > conv1_pkg::OUT_MAX) begin
      result = conv1_pkg::BW_ACT'(conv1_pkg::OUT_MAX);
    end else begin
      result = shifted[conv1_pkg::BW_ACT-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      cmd_out  <= '0;
      done_out <= 1'b0;
    end else begin
      cmd_out  <= cmd_in;
      done_out <= done_in;
    end
  end

  always_ff @(posedge clk) begin
    pixel <= result;
  end

endmodule

// File: source/conv1_writeback.sv
`timescale 1ns/1ps

module conv1_writeback (
  input  logic                         clk,
  input  logic                         srst_n,
  input  logic [conv1_pkg::BW_ACT-1:0] pixel,
  input  conv1_pkg::wb_cmd_t           cmd_in,
  input  logic                         done_in,
  output conv1_pkg::out_wr_t           out_wr [4],
  output logic                         valid
);

  localparam conv1_pkg::out_wr_t wr_idle = '{wen: 1'b1, addr: '0, wordmask: '1, wdata: '0};

  logic [3:0]         y;      // output pixel row
  logic [3:0]         x;      // output pixel column
  logic [1:0]         bank;
  logic [1:0]         lane;
  logic [1:0]         slice;
  logic [4:0]         addr;
  logic               done_q;
  conv1_pkg::out_wr_t wr;

  // ============================================================
  // placement
  // ============================================================
  assign y     = {cmd_in.row, cmd_in.sub[1]};
  assign x     = {cmd_in.col, cmd_in.sub[0]};
  assign bank  = {y[0], x[0]};
  assign lane  = {y[1], x[1]};
  assign slice = cmd_in.ofmap[1:0];
  // maps 4..7 go to the upper half
  assign addr  = 5'(3 * y[3:2]) + 5'(x[3:2]) + (cmd_in.ofmap[2] ? 5'd9 : 5'd0);

  always_comb begin
    wr                      = wr_idle;
    wr.wen                  = 1'b0;
    wr.addr                 = addr;
    wr.wordmask[slice][lane] = 1'b0;
    wr.wdata[slice][lane]    = pixel;
  end

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      for (int b = 0; b < 4; b++) begin
        out_wr[b] <= wr_idle;
      end
      done_q <= 1'b0;
      valid  <= 1'b0;
    end else begin
      for (int b = 0; b < 4; b++) begin
        out_wr[b] <= (cmd_in.fire && bank == 2'(b)) ? wr : wr_idle;
      end
      done_q <= done_in;
      valid  <= done_q;  // cycle after the last write
    end
  end

endmodule

// File: source/conv1_top.sv
`timescale 1ns/1ps

module conv1_top #(
  parameter int OFMAP_NUM = 8
) (
  input  logic                           clk,
  input  logic                           srst_n,
  input  logic                           enable,
  output logic                           valid,
  output conv1_pkg::act_rd_t             act_rd,
  input  conv1_pkg::act_word_t           act_rdata [4],
  output logic [8:0]                     weight_raddr,
  input  conv1_pkg::weight_word_t        weight_rdata,
  output logic [5:0]                     bias_raddr,
  input  logic [conv1_pkg::BW_PARAM-1:0] bias_rdata,
  output conv1_pkg::out_wr_t             out_wr [4]
);

  logic [1:0]                     load_idx;
  logic                           load_strobe;
  conv1_pkg::wb_cmd_t             seq_cmd;
  conv1_pkg::wb_cmd_t             buf_cmd;
  conv1_pkg::wb_cmd_t             pe_cmd;
  logic                           seq_done;
  logic                           buf_done;
  logic                           pe_done;
  conv1_pkg::act_word_t           window [4];
  conv1_pkg::weight_word_t        weights [4];
  logic [conv1_pkg::BW_PARAM-1:0] bias;
  logic [conv1_pkg::BW_ACT-1:0]   pixel;

  conv1_sequencer #(
    .OFMAP_NUM (OFMAP_NUM)
  ) u_sequencer (
    .clk          (clk),
    .srst_n       (srst_n),
    .enable       (enable),
    .act_rd       (act_rd),
    .weight_raddr (weight_raddr),
    .bias_raddr   (bias_raddr),
    .load_idx     (load_idx),
    .load_strobe  (load_strobe),
    .cmd          (seq_cmd),
    .done         (seq_done)
  );

  conv1_operand_buffer u_operand_buffer (
    .clk          (clk),
    .srst_n       (srst_n),
    .act_rdata    (act_rdata),
    .weight_rdata (weight_rdata),
    .bias_rdata   (bias_rdata),
    .load_idx     (load_idx),
    .load_strobe  (load_strobe),
    .cmd_in       (seq_cmd),
    .done_in      (seq_done),
    .window       (window),
    .weights      (weights),
    .bias         (bias),
    .cmd_out      (buf_cmd),
    .done_out     (buf_done)
  );

  conv1_pe u_pe (
    .clk      (clk),
    .srst_n   (srst_n),
    .window   (window),
    .weights  (weights),
    .bias     (bias),
    .cmd_in   (buf_cmd),
    .done_in  (buf_done),
    .pixel    (pixel),
    .cmd_out  (pe_cmd),
    .done_out (pe_done)
  );

  conv1_writeback u_writeback (
    .clk     (clk),
    .srst_n  (srst_n),
    .pixel   (pixel),
    .cmd_in  (pe_cmd),
    .done_in (pe_done),
    .out_wr  (out_wr),
    .valid   (valid)
  );

endmodule

// File: bench/conv1_properties.sv
`timescale 1ns/1ps

module conv1_properties (
  input logic               clk,
  input logic               srst_n,
  input conv1_pkg::out_wr_t out_wr [4],
  input logic               valid
);

  logic [3:0] wen_low;

  assign wen_low = {~out_wr[3].wen, ~out_wr[2].wen, ~out_wr[1].wen, ~out_wr[0].wen};

  // one output pixel per cycle
  one_bank_per_cycle: assert property (@(posedge clk) disable iff (!srst_n)
    $countones(wen_low) <= 1)
    else $error("more than one C bank written in the same cycle");

  for (genvar b = 0; b < 4; b++) begin : g_bank
    one_lane_per_write: assert property (@(posedge clk) disable iff (!srst_n)
      !out_wr[b].wen |-> $countones(~out_wr[b].wordmask) == 1)
      else $error("bank %0d write does not clear exactly one mask bit", b);
  end

  valid_pulse: assert property (@(posedge clk) disable iff (!srst_n) valid |=> !valid)
    else $error("valid held high for more than one cycle");

endmodule

bind conv1_writeback conv1_properties u_properties (
  .clk    (clk),
  .srst_n (srst_n),
  .out_wr (out_wr),
  .valid  (valid)
);

// File: bench/conv1_tb.sv
`timescale 1ns/1ps

module conv1_tb;

  localparam int maps     = 8;
  localparam int side     = 16;   // padded input pixels per side
  localparam int out_side = 12;
  localparam conv1_pkg::out_wr_t wr_idle = '{wen: 1'b1, addr: '0, wordmask: '1, wdata: '0};

  logic                           clk = 1'b0;
  logic                           srst_n = 1'b0;
  logic                           enable = 1'b0;
  logic                           valid;
  conv1_pkg::act_rd_t             act_rd;
  conv1_pkg::act_word_t           act_rdata [4];
  logic [8:0]                     weight_raddr;
  conv1_pkg::weight_word_t        weight_rdata;
  logic [5:0]                     bias_raddr;
  logic [conv1_pkg::BW_PARAM-1:0] bias_rdata;
  conv1_pkg::out_wr_t             out_wr [4];

  logic [71:0]                    stim [42];
  conv1_pkg::act_word_t           act_mem [4][16];
  conv1_pkg::weight_word_t        wgt_mem [32];
  logic [conv1_pkg::BW_PARAM-1:0] bias_mem [8];
  conv1_pkg::act_word_t           c_mem [4][32];
  int                             img [conv1_pkg::CH_NUM][side][side];
  int                             ref_pix [maps][out_side][out_side];
  bit                             written [maps][out_side][out_side];
  integer                         seed = 59140;
  int                             runs = 0;
  int                             write_cnt = 0;
  int                             valid_cnt = 0;
  int                             value_errs = 0;
  int                             other_errs = 0;
  bit                             stim_loaded = 1'b0;

  always #4 clk = ~clk;

  conv1_top #(
    .OFMAP_NUM (maps)
  ) u_dut (
    .clk          (clk),
    .srst_n       (srst_n),
    .enable       (enable),
    .valid        (valid),
    .act_rd       (act_rd),
    .act_rdata    (act_rdata),
    .weight_raddr (weight_raddr),
    .weight_rdata (weight_rdata),
    .bias_raddr   (bias_raddr),
    .bias_rdata   (bias_rdata),
    .out_wr       (out_wr)
  );

  // ============================================================
  // SRAM models
  // ============================================================
  initial begin : sram_model
    conv1_pkg::act_rd_t ra;
    logic [8:0]         wa;
    logic [5:0]         ba;
    for (int b = 0; b < 4; b++) begin
      act_rdata[b] = '0;
    end
    weight_rdata = '0;
    bias_rdata   = '0;
    forever begin
      @(posedge clk);
      ra = act_rd;
      wa = weight_raddr;
      ba = bias_raddr;
      #1;  // data shows up the cycle after the address
      act_rdata[0] = act_mem[0][ra.a0[3:0]];
      act_rdata[1] = act_mem[1][ra.a1[3:0]];
      act_rdata[2] = act_mem[2][ra.a2[3:0]];
      act_rdata[3] = act_mem[3][ra.a3[3:0]];
      weight_rdata = wgt_mem[wa[4:0]];
      bias_rdata   = bias_mem[ba[2:0]];
    end
  end

  task automatic build_inputs();
    int bank;
    int addr;
    for (int c = 0; c < conv1_pkg::CH_NUM; c++) begin
      for (int py = 0; py < side; py++) begin
        for (int px = 0; px < side; px++) begin
          if (py >= 1 && py <= out_side && px >= 1 && px <= out_side) begin
            img[c][py][px] = $random(seed) & 255;
          end else begin
            img[c][py][px] = 0;  // zero border
          end
        end
      end
    end
    for (int qy = 0; qy < side / 2; qy++) begin
      for (int qx = 0; qx < side / 2; qx++) begin
        bank = (qy % 2) * 2 + qx % 2;
        addr = 4 * (qy / 2) + qx / 2;
        for (int c = 0; c < conv1_pkg::CH_NUM; c++) begin
          for (int l = 0; l < 4; l++) begin
            act_mem[bank][addr][c][l] = 12'(img[c][2 * qy + l / 2][2 * qx + l % 2]);
          end
        end
      end
    end
    for (int m = 0; m < maps; m++) begin
      for (int c = 0; c < conv1_pkg::CH_NUM; c++) begin
        wgt_mem[4 * m + c] = stim[2 + 5 * m + c];
      end
      bias_mem[m] = stim[2 + 5 * m + 4][7:0];
    end
  endtask

  // ============================================================
  // reference model
  // ============================================================
  task automatic build_reference();
    int acc;
    int zeros;
    int peaks;
    zeros = 0;
    peaks = 0;
    for (int m = 0; m < maps; m++) begin
      for (int y = 0; y < out_side; y++) begin
        for (int x = 0; x < out_side; x++) begin
          acc = int'($signed(bias_mem[m])) * (1 << conv1_pkg::ACC_SHIFT);
          for (int c = 0; c < conv1_pkg::CH_NUM; c++) begin
            for (int k = 0; k < conv1_pkg::TAPS; k++) begin
              acc += int'($signed(wgt_mem[4 * m + c][k])) * img[c][y + k / 3][x + k % 3];
            end
          end
          if (acc < 0) begin
            ref_pix[m][y][x] = 0;
          end else if ((acc >> conv1_pkg::ACC_SHIFT) > conv1_pkg::OUT_MAX) begin
            ref_pix[m][y][x] = conv1_pkg::OUT_MAX;
          end else begin
            ref_pix[m][y][x] = acc >> conv1_pkg::ACC_SHIFT;
          end
          if (m == 6 && ref_pix[m][y][x] == 0) zeros++;
          if (m == 7 && ref_pix[m][y][x] == conv1_pkg::OUT_MAX) peaks++;
        end
      end
    end
    if (zeros == 0 || peaks == 0) begin
      other_errs++;
      $display("stimulus misses ReLU clipping on map 6 or saturation on map 7");
    end
  endtask

  // bank, address, slice and lane back to map and output pixel
  function automatic void locate(input int b, input int a, input int s, input int l,
                                 output int m, output int y, output int x);
    m = s + 4 * (a / 9);
    y = 4 * ((a % 9) / 3) + 2 * (l / 2) + b / 2;
    x = 4 * ((a % 9) % 3) + 2 * (l % 2) + b % 2;
  endfunction

  task automatic clear_outputs();
    for (int b = 0; b < 4; b++) begin
      for (int a = 0; a < 32; a++) begin
        for (int s = 0; s < 4; s++) begin
          for (int l = 0; l < 4; l++) begin
            c_mem[b][a][s][l] = {1'b1, 2'(b), 5'(a), 2'(s), 2'(l)};  // never a legal pixel
          end
        end
      end
    end
    written = '{default: '0};
  endtask

  task automatic check_pixel(input logic [conv1_pkg::BW_ACT-1:0] exp_px,
                             input logic [conv1_pkg::BW_ACT-1:0] got_px, input string what);
    if (got_px !== exp_px) begin
      value_errs++;
      $display("error at %0t: %s got %0d, expected %0d", $time, what, got_px, exp_px);
    end
  endtask

  task automatic check_write(input conv1_pkg::out_wr_t exp_wr, input conv1_pkg::out_wr_t got,
                             input int b);
    if (got.wen !== exp_wr.wen || got.wordmask !== exp_wr.wordmask ||
        got.wdata !== exp_wr.wdata) begin
      value_errs++;
      $display("error at %0t: bank %0d port wen %b addr %0d mask %h data %h", $time, b,
               got.wen, got.addr, got.wordmask, got.wdata);
      $display("  expected wen %b mask %h data %h", exp_wr.wen, exp_wr.wordmask,
               exp_wr.wdata);
    end
  endtask

  task automatic observe_write(input int b, input conv1_pkg::out_wr_t wr);
    int s;
    int l;
    int m;
    int y;
    int x;
    conv1_pkg::out_wr_t exp_wr;
    s = -1;
    l = 0;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        if (!wr.wordmask[i][j] && s < 0) begin
          s = i;
          l = j;
        end
      end
    end
    write_cnt++;
    if (s < 0 || int'(wr.addr) >= 9 * maps / 4) begin
      other_errs++;
      $display("bank %0d write to address %0d enables no lane or lies outside the layer",
               b, wr.addr);
      return;
    end
    locate(b, int'(wr.addr), s, l, m, y, x);
    if (written[m][y][x]) begin
      other_errs++;
      $display("map %0d pixel y %0d x %0d was written twice in one run", m, y, x);
    end
    written[m][y][x] = 1'b1;
    exp_wr                = wr_idle;
    exp_wr.wen            = 1'b0;
    exp_wr.wordmask[s][l] = 1'b0;
    exp_wr.wdata[s][l]    = 12'(ref_pix[m][y][x]);
    check_write(exp_wr, wr, b);
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        if (!wr.wordmask[i][j]) c_mem[b][wr.addr][i][j] = wr.wdata[i][j];
      end
    end
  endtask

  task automatic compare_contents(input int run);
    int m;
    int y;
    int x;
    for (int b = 0; b < 4; b++) begin
      for (int a = 0; a < 9 * maps / 4; a++) begin
        for (int s = 0; s < 4; s++) begin
          for (int l = 0; l < 4; l++) begin
            locate(b, a, s, l, m, y, x);
            check_pixel(12'(ref_pix[m][y][x]), c_mem[b][a][s][l],
                        $sformatf("run %0d map %0d pixel y %0d x %0d", run, m, y, x));
          end
        end
      end
    end
  endtask

  // ============================================================
  // C bank monitor
  // ============================================================
  always @(posedge clk) begin
    if (srst_n) begin
      for (int b = 0; b < 4; b++) begin
        if (out_wr[b].wen) begin
          check_write(wr_idle, out_wr[b], b);
        end else begin
          observe_write(b, out_wr[b]);
        end
      end
      if (valid) valid_cnt++;
    end
  end

  initial begin : main
    int exp_writes;
    $readmemh("bench/conv1_stim.txt", stim);
    runs       = int'(stim[0]);
    exp_writes = int'(stim[1]);
    build_inputs();
    build_reference();
    stim_loaded = 1'b1;
    repeat (4) @(posedge clk);
    #1 srst_n = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    if (write_cnt != 0 || valid_cnt != 0) begin
      other_errs++;
      $display("DUT wrote to a C bank or raised valid before enable");
    end
    for (int r = 0; r < runs; r++) begin
      clear_outputs();
      write_cnt = 0;
      valid_cnt = 0;
      enable    = 1'b1;
      @(posedge clk);
      #1 enable = 1'b0;
      while (valid_cnt == 0) begin
        @(posedge clk);
        #1;
      end
      if (write_cnt != exp_writes) begin
        other_errs++;
        $display("run %0d raised valid after %0d of %0d C writes", r, write_cnt, exp_writes);
      end
      repeat (8) @(posedge clk);  // late writes or a second valid would show here
      #1;
      if (write_cnt != exp_writes) begin
        other_errs++;
        $display("run %0d made %0d C writes instead of %0d", r, write_cnt, exp_writes);
      end
      if (valid_cnt != 1) begin
        other_errs++;
        $display("run %0d raised valid %0d times instead of once", r, valid_cnt);
      end
      compare_contents(r);
    end
    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    wait (stim_loaded);
    repeat (runs * 1400 + 100) @(posedge clk);
    $display("timeout: run not finished within %0d cycles", runs * 1400 + 100);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: bench/conv1_stim.txt
// one hex word per line: run count, C writes per run, then for each map
// four weight words for channels 0 to 3 (tap 0 in the top byte) and the bias
2                   // runs
480                 // C writes per run
010201000000FFFEFF  // map 0 ch 0
0200FE0300FD0200FE  // map 0 ch 1
00010001FC01000100  // map 0 ch 2
FFFFFFFF08FFFFFFFF  // map 0 ch 3
10                  // map 0 bias
030303000000000000  // map 1 ch 0
000000000000FDFDFD  // map 1 ch 1
0100FF0200FE0100FF  // map 1 ch 2
04FC04FC04FC04FC04  // map 1 ch 3
F0                  // map 1 bias
020202020202020202  // map 2 ch 0
FEFEFEFEFEFEFEFEFE  // map 2 ch 1
000000000500000000  // map 2 ch 2
01FF01FF01FF01FF01  // map 2 ch 3
05                  // map 2 bias
0700000000000000F9  // map 3 ch 0
000006000000FA0000  // map 3 ch 1
010203040504030201  // map 3 ch 2
FBFCFDFE00FEFDFCFB  // map 3 ch 3
00                  // map 3 bias
100000000000000000  // map 4 ch 0
000000001000000000  // map 4 ch 1
0000000000000000F0  // map 4 ch 2
00F800F800F800F800  // map 4 ch 3
20                  // map 4 bias
05FB05FB05FB05FB05  // map 5 ch 0
030000000300000003  // map 5 ch 1
0000FC00FC00FC0000  // map 5 ch 2
020100010201000102  // map 5 ch 3
E0                  // map 5 bias
01FFFE01FFFE01FFFE  // map 6 ch 0
FF00FF000200FF00FF  // map 6 ch 1
FEFEFEFEFEFEFEFEFE  // map 6 ch 2
000100FFFFFF000100  // map 6 ch 3
80                  // map 6 bias, large negative
7F7F7F7F7F7F7F7F7F  // map 7 ch 0
7F7F7F7F7F7F7F7F7F  // map 7 ch 1
404040404040404040  // map 7 ch 2
7F7F7F7F7F7F7F7F7F  // map 7 ch 3
7F                  // map 7 bias, large positive

// File: sources.f
source/conv1_pkg.sv
source/conv1_sequencer.sv
source/conv1_operand_buffer.sv
source/conv1_pe.sv
source/conv1_writeback.sv
source/conv1_top.sv
bench/conv1_properties.sv
bench/conv1_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= conv1_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
